// File: include/nic_phy_tb_tasks.svh
`ifndef NIC_PHY_TB_TASKS_SVH
`define NIC_PHY_TB_TASKS_SVH

int value_errors;
int other_errors;

function automatic void report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	value_errors++;
	$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
endfunction

function automatic void report_problem(input string what);
	other_errors++;
	$display("ERROR: %s", what);
endfunction

// Image word from the board IDs, checksum slot left out
function automatic logic [15:0] expected_word(input logic [5:0] addr);
	logic [47:0] mac;
	logic [7:0] b [6];
	mac = {TB_MAC_OUI, TB_MAC_NIC};
	for (int i = 0; i < 6; i++) begin
		b[i] = mac[47 - 8 * i -: 8];
	end
	case (addr)
		6'h00: return {b[1], b[0]};
		6'h01: return {b[3], b[2]};
		6'h02: return {b[5], b[4]};
		6'h0B: return TB_SUB_PID;
		6'h0C: return TB_SUB_VID;
		6'h0D: return TB_PID;
		6'h0E: return TB_VID;
		default: return 16'h0000;
	endcase
endfunction

// One sk period, do sampled late in the low phase
task automatic sk_cycle(input logic di_bit, output logic do_bit);
	ee_di = di_bit;
	repeat (SK_HALF) @(negedge clk);
	ee_sk = 1'b1;
	repeat (SK_HALF) @(negedge clk);
	ee_sk = 1'b0;
	repeat (SK_HALF) @(negedge clk);
	do_bit = ee_do;
endtask

// Start bit, opcode, address, then the dummy bit and 16 data bits
task automatic ee_frame(input logic [1:0] op, input logic [5:0] addr,
		output logic [15:0] word);
	logic [8:0] cmd;
	logic bit_o;
	cmd = {1'b1, op, addr};
	word = '0;
	@(negedge clk);
	ee_cs = 1'b1;
	for (int i = 8; i >= 0; i--) begin
		sk_cycle(cmd[i], bit_o);
	end
	if (op == TB_OP_READ && bit_o !== 1'b0) begin
		report_mismatch("ee_do_o dummy", 32'(bit_o), 32'h0);
	end
	for (int i = 0; i < 16; i++) begin
		sk_cycle(1'b0, bit_o);
		word = {word[14:0], bit_o};
	end
	ee_cs = 1'b0;
	repeat (SK_HALF) @(negedge clk);
endtask

task automatic check_word(input logic [5:0] addr, output logic [15:0] word);
	ee_frame(TB_OP_READ, addr, word);
	if (addr != 6'h3F && word !== expected_word(addr)) begin
		report_mismatch($sformatf("ee_do_o @0x%0h", addr), 32'(word),
			32'(expected_word(addr)));
	end
endtask

`endif

// File: dv/nic_phy_tb.sv
module nic_phy_tb;
	import nic_phy_pkg::*;

	localparam logic [23:0] TB_MAC_OUI = 24'h001B21;
	localparam logic [23:0] TB_MAC_NIC = 24'h3C4D5E;
	localparam logic [15:0] TB_SUB_PID = 16'h0A51;
	localparam logic [15:0] TB_SUB_VID = 16'h17AA;
	localparam logic [15:0] TB_PID = 16'h10D3;
	localparam logic [15:0] TB_VID = 16'h8086;
	localparam int HOLDOFF = 12;
	localparam int SK_HALF = 4;
	localparam logic [1:0] TB_OP_READ = 2'b10;
	localparam logic [15:0] TB_IMAGE_SUM = 16'hBABA;

	logic clk;
	logic rst_n;
	logic ee_sk;
	logic ee_cs;
	logic ee_di;
	logic ee_do;
	phy_status_t phy0_status;
	phy_status_t phy1_status;
	gmii_rx_t phy0_rx;
	gmii_rx_t phy1_rx;
	gmii_rx_t mac_rx;
	gmii_tx_t phy0_tx;
	gmii_tx_t phy1_tx;
	gmii_tx_t mac_tx;
	logic active_port;
	logic link_up;
	logic link_change;
	link_speed_e speed;

	// Checker state set by the sequence
	logic port_stable;
	logic exp_port;
	logic quiet_do;
	logic traffic_on;
	logic mux_on_q;
	gmii_rx_t exp_rx_q;
	gmii_tx_t exp_tx0_q;
	gmii_tx_t exp_tx1_q;

	`include "nic_phy_tb_tasks.svh"

	initial clk = 1'b0;
	always #50 clk = ~clk;

	nic_phy_top #(
		.MAC_OUI(TB_MAC_OUI), .MAC_NIC(TB_MAC_NIC), .SUB_PID(TB_SUB_PID),
		.SUB_VID(TB_SUB_VID), .PID(TB_PID), .VID(TB_VID), .HOLDOFF_CYCLES(HOLDOFF)
	) i_dut (
		.clk_i(clk), .rst_n_i(rst_n), .ee_sk_i(ee_sk), .ee_cs_i(ee_cs), .ee_di_i(ee_di),
		.ee_do_o(ee_do), .phy0_status_i(phy0_status), .phy1_status_i(phy1_status),
		.phy0_rx_i(phy0_rx), .phy1_rx_i(phy1_rx), .phy0_tx_o(phy0_tx), .phy1_tx_o(phy1_tx),
		.mac_tx_i(mac_tx), .mac_rx_o(mac_rx), .active_port_o(active_port),
		.link_up_o(link_up), .speed_o(speed), .link_change_o(link_change)
	);

	////////////////////////////////////////
	// Random GMII traffic and routing model

	always @(negedge clk) begin
		logic [31:0] rnd;
		if (traffic_on) begin
			rnd = $urandom;
			phy0_rx = rnd[9:0];
			phy1_rx = rnd[19:10];
			mac_tx = rnd[29:20];
		end
	end

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mux_on_q <= 1'b0;
			exp_rx_q <= '0;
			exp_tx0_q <= '0;
			exp_tx1_q <= '0;
		end else begin
			mux_on_q <= port_stable;
			exp_rx_q <= exp_port ? phy1_rx : phy0_rx;
			exp_tx0_q <= exp_port ? '0 : mac_tx;
			exp_tx1_q <= exp_port ? mac_tx : '0;
		end
	end

	a_port_hold: assert property (@(posedge clk) disable iff (!rst_n)
		port_stable |-> active_port == exp_port)
		else report_mismatch("active_port_o", 32'(active_port), 32'(exp_port));
	a_rx_route: assert property (@(posedge clk) disable iff (!rst_n)
		mux_on_q |-> mac_rx == exp_rx_q)
		else report_mismatch("mac_rx_o", 32'(mac_rx), 32'(exp_rx_q));
	a_tx0_route: assert property (@(posedge clk) disable iff (!rst_n)
		mux_on_q |-> phy0_tx == exp_tx0_q)
		else report_mismatch("phy0_tx_o", 32'(phy0_tx), 32'(exp_tx0_q));
	a_tx1_route: assert property (@(posedge clk) disable iff (!rst_n)
		mux_on_q |-> phy1_tx == exp_tx1_q)
		else report_mismatch("phy1_tx_o", 32'(phy1_tx), 32'(exp_tx1_q));
	a_do_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		quiet_do |-> !ee_do)
		else report_mismatch("ee_do_o", 32'(ee_do), 32'h0);

	////////////////////////////////////////
	// Sequence

	initial begin
		int waited;
		int pulses;
		int j;
		int tmp;
		int order [64];
		logic [5:0] id_addrs [7];
		logic [15:0] word;
		logic [15:0] sum;
		void'($urandom(32'h533d_884e));
		value_errors = 0;
		other_errors = 0;
		{ee_sk, ee_cs, ee_di} = 3'b000;
		phy0_status = '{1'b1, SPEED_1000};
		phy1_status = '{1'b1, SPEED_100};
		phy0_rx = '0;
		phy1_rx = '0;
		mac_tx = '0;
		{traffic_on, port_stable, exp_port, quiet_do} = 4'b0000;
		rst_n = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		{traffic_on, port_stable} = 2'b11;

		id_addrs = '{6'h00, 6'h01, 6'h02, 6'h0B, 6'h0C, 6'h0D, 6'h0E};
		foreach (id_addrs[i]) begin
			check_word(id_addrs[i], word);
		end

		// Whole image in shuffled order
		for (int i = 0; i < 64; i++) begin
			order[i] = i;
		end
		for (int i = 63; i > 0; i--) begin
			j = $urandom_range(i, 0);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		sum = '0;
		for (int i = 0; i < 64; i++) begin
			check_word(6'(order[i]), word);
			sum = sum + word;
		end
		if (sum !== TB_IMAGE_SUM) begin
			report_mismatch("image sum", 32'(sum), 32'(TB_IMAGE_SUM));
		end

		quiet_do = 1'b1;
		ee_frame(2'b11, 6'h15, word);
		quiet_do = 1'b0;

		// Short outage stays on port 0
		phy0_status.up = 1'b0;
		repeat (HOLDOFF - 2) @(negedge clk);
		phy0_status.up = 1'b1;
		repeat (4) @(negedge clk);

		port_stable = 1'b0;
		phy0_status.up = 1'b0;
		waited = 0;
		while (active_port !== 1'b1 && waited < 4 * HOLDOFF) begin
			@(negedge clk);
			waited++;
		end
		if (active_port !== 1'b1) begin
			report_problem("timeout waiting for failover to port 1");
		end else if (waited != HOLDOFF) begin
			report_mismatch("failover delay", 32'(waited), 32'(HOLDOFF));
		end
		if (link_up !== 1'b1 || speed !== SPEED_100) begin
			report_mismatch("link_up_o/speed_o", {link_up, 2'(speed)}, {1'b1, 2'(SPEED_100)});
		end
		{port_stable, exp_port} = 2'b11;
		pulses = 0;
		repeat (6) begin
			@(negedge clk);
			pulses += int'(link_change);
		end
		if (pulses != 1) begin
			report_mismatch("link_change_o pulses", 32'(pulses), 32'h1);
		end
		phy0_status.up = 1'b1;
		repeat (2 * HOLDOFF) @(negedge clk);

		// Both ports down
		phy0_status.up = 1'b0;
		phy1_status.up = 1'b0;
		waited = 0;
		while (link_up !== 1'b0 && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		if (link_up !== 1'b0) begin
			report_problem("timeout waiting for link_up_o to drop");
		end
		repeat (2 * HOLDOFF) @(negedge clk);

		$display("Checks done: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: nic_phy_top.f
+incdir+include
verilog/nic_phy_pkg.sv
verilog/config_rom.sv
verilog/eeprom_emu.sv
verilog/phy_failover.sv
verilog/gmii_port_mux.sv
verilog/nic_phy_top.sv
dv/nic_phy_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the nic_phy testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module nic_phy_tb -f nic_phy_top.f -o nic_phy_sim

./obj_dir/nic_phy_sim | tee sim.log

if grep -q "^TEST PASSED$" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi

// File: verilog/config_rom.sv
module config_rom #(
	parameter logic [23:0] MAC_OUI = 24'hEC3F05,
	parameter logic [23:0] MAC_NIC = 24'h5A0001,
	parameter logic [15:0] SUB_PID = 16'h6120,
	parameter logic [15:0] SUB_VID = 16'hFACE,
	parameter logic [15:0] PID = 16'hABCD,
	parameter logic [15:0] VID = 16'h8086
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic rd_en_i,
	input  logic [nic_phy_pkg::EE_ADDR_W-1:0] rd_addr_i,
	output logic [nic_phy_pkg::EE_WORD_W-1:0] rd_data_o
);
	import nic_phy_pkg::*;

	// MAC bytes b0..b5 from the top down
	localparam logic [47:0] MAC = {MAC_OUI, MAC_NIC};

	ee_image_t image;

	always_comb begin
		image = '0;
		// Word k is {b(2k+1), b(2k)}
		for (int k = 0; k < 3; k++) begin
			image[k] = {MAC[39-16*k -: 8], MAC[47-16*k -: 8]};
		end
		image[EE_ADDR_SUB_PID] = SUB_PID;
		image[EE_ADDR_SUB_VID] = SUB_VID;
		image[EE_ADDR_PID] = PID;
		image[EE_ADDR_VID] = VID;
		image[EE_ADDR_CSUM] = ee_checksum(image);
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rd_data_o <= '0;
		end else if (rd_en_i) begin
			rd_data_o <= image[rd_addr_i];
		end
	end

	// Requester must leave a gap between reads
	a_rd_en_gap: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		rd_en_i |=> !rd_en_i
	);

endmodule

// File: verilog/eeprom_emu.sv
module eeprom_emu (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic sk_i,
	input  logic cs_i,
	input  logic di_i,
	output logic do_o,
	output logic rom_rd_en_o,
	output logic [nic_phy_pkg::EE_ADDR_W-1:0] rom_addr_o,
	input  logic [nic_phy_pkg::EE_WORD_W-1:0] rom_data_i
);
	import nic_phy_pkg::*;

	// Start bit, two opcode bits, then the address
	localparam int CMD_BITS = 3 + EE_ADDR_W;
	localparam int DATA_END = CMD_BITS + EE_WORD_W;

	logic [2:0] sk_q;
	logic [1:0] cs_q;
	logic [1:0] di_q;
	logic sk_rise;
	logic cs_s;
	logic di_s;

	logic [4:0] bit_cnt;
	logic [EE_ADDR_W:0] cmd_q;
	logic [EE_WORD_W-1:0] data_q;
	logic frame_rd;

	////////////////////////////////////////
	// Pin synchronizers

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sk_q <= '0;
			cs_q <= '0;
			di_q <= '0;
		end else begin
			sk_q <= {sk_q[1:0], sk_i};
			cs_q <= {cs_q[0], cs_i};
			di_q <= {di_q[0], di_i};
		end
	end

	assign sk_rise = sk_q[1] & ~sk_q[2];
	assign cs_s = cs_q[1];
	assign di_s = di_q[1];

	////////////////////////////////////////
	// Command decode and shift out

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bit_cnt <= '0;
			cmd_q <= '0;
			data_q <= '0;
			frame_rd <= 1'b0;
			rom_rd_en_o <= 1'b0;
			rom_addr_o <= '0;
			do_o <= 1'b0;
		end else if (!cs_s) begin
			bit_cnt <= '0;
			frame_rd <= 1'b0;
			rom_rd_en_o <= 1'b0;
			do_o <= 1'b0;
		end else begin
			rom_rd_en_o <= 1'b0;
			if (sk_rise) begin
				// Leading zeros before the start bit are ignored
				if (bit_cnt != '1 && (bit_cnt != '0 || di_s)) begin
					bit_cnt <= bit_cnt + 5'd1;
				end
				if (bit_cnt >= 5'd1 && bit_cnt < 5'(CMD_BITS - 1)) begin
					cmd_q <= {cmd_q[EE_ADDR_W-1:0], di_s};
				end

				if (bit_cnt == 5'(CMD_BITS - 1) && cmd_q[EE_ADDR_W -: 2] == EE_OP_READ) begin
					rom_rd_en_o <= 1'b1;
					rom_addr_o <= {cmd_q[EE_ADDR_W-2:0], di_s};
					frame_rd <= 1'b1;
					// Dummy zero ahead of the data
					do_o <= 1'b0;
				end else if (frame_rd && bit_cnt == 5'(CMD_BITS)) begin
					do_o <= rom_data_i[EE_WORD_W-1];
					data_q <= {rom_data_i[EE_WORD_W-2:0], 1'b0};
				end else if (frame_rd && bit_cnt < 5'(DATA_END)) begin
					do_o <= data_q[EE_WORD_W-1];
					data_q <= {data_q[EE_WORD_W-2:0], 1'b0};
				end else begin
					do_o <= 1'b0;
				end
			end
		end
	end

	a_one_read_per_frame: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		rom_rd_en_o |-> !$past(frame_rd)
	);

	// Low cs pin reaches do_o through the synchronizer
	a_do_idle: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		!$past(cs_i, 3) |-> !do_o
	);

endmodule

// File: verilog/gmii_port_mux.sv
module gmii_port_mux (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic active_port_i,
	input  nic_phy_pkg::gmii_rx_t phy0_rx_i,
	input  nic_phy_pkg::gmii_rx_t phy1_rx_i,
	input  nic_phy_pkg::gmii_tx_t mac_tx_i,
	output nic_phy_pkg::gmii_rx_t mac_rx_o,
	output nic_phy_pkg::gmii_tx_t phy0_tx_o,
	output nic_phy_pkg::gmii_tx_t phy1_tx_o
);
	import nic_phy_pkg::*;

	gmii_rx_t rx_sel;
	gmii_tx_t tx0_next;
	gmii_tx_t tx1_next;

	assign rx_sel = active_port_i ? phy1_rx_i : phy0_rx_i;

	// Standby port sees an idle transmitter
	assign tx0_next = active_port_i ? gmii_tx_t'('0) : mac_tx_i;
	assign tx1_next = active_port_i ? mac_tx_i : gmii_tx_t'('0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mac_rx_o <= '0;
			phy0_tx_o <= '0;
			phy1_tx_o <= '0;
		end else begin
			mac_rx_o <= rx_sel;
			phy0_tx_o <= tx0_next;
			phy1_tx_o <= tx1_next;
		end
	end

endmodule

// File: verilog/nic_phy_pkg.sv
package nic_phy_pkg;

	////////////////////////////////////////
	// EEPROM geometry and contents

	localparam int EE_ADDR_W = 6;
	localparam int EE_WORD_W = 16;
	localparam int EE_WORDS = 1 << EE_ADDR_W;

	localparam logic [1:0] EE_OP_READ = 2'b10;
	localparam logic [EE_WORD_W-1:0] EE_CHECKSUM = 16'hBABA;

	localparam logic [EE_ADDR_W-1:0] EE_ADDR_SUB_PID = 6'h0B;
	localparam logic [EE_ADDR_W-1:0] EE_ADDR_SUB_VID = 6'h0C;
	localparam logic [EE_ADDR_W-1:0] EE_ADDR_PID = 6'h0D;
	localparam logic [EE_ADDR_W-1:0] EE_ADDR_VID = 6'h0E;
	localparam logic [EE_ADDR_W-1:0] EE_ADDR_CSUM = 6'h3F;

	typedef logic [EE_WORDS-1:0][EE_WORD_W-1:0] ee_image_t;

	////////////////////////////////////////
	// GMII and PHY status

	typedef struct packed {
		logic [7:0] rxd;
		logic rx_dv;
		logic rx_er;
	} gmii_rx_t;

	typedef struct packed {
		logic [7:0] txd;
		logic tx_en;
		logic tx_er;
	} gmii_tx_t;

	typedef enum logic [1:0] {
		SPEED_10 = 2'b00,
		SPEED_100 = 2'b01,
		SPEED_1000 = 2'b10
	} link_speed_e;

	typedef struct packed {
		logic up;
		link_speed_e speed;
	} phy_status_t;

	// Word that brings the image sum to EE_CHECKSUM, checksum slot excluded
	function automatic logic [EE_WORD_W-1:0] ee_checksum(input ee_image_t image);
		logic [EE_WORD_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < EE_WORDS; i++) begin
			if (i != int'(EE_ADDR_CSUM)) begin
				sum = sum + image[i];
			end
		end
		return EE_CHECKSUM - sum;
	endfunction

endpackage

// File: verilog/nic_phy_top.sv
module nic_phy_top #(
	parameter logic [23:0] MAC_OUI = 24'hEC3F05,
	parameter logic [23:0] MAC_NIC = 24'h5A0001,
	parameter logic [15:0] SUB_PID = 16'h6120,
	parameter logic [15:0] SUB_VID = 16'hFACE,
	parameter logic [15:0] PID = 16'hABCD,
	parameter logic [15:0] VID = 16'h8086,
	parameter int HOLDOFF_CYCLES = 16
) (
	input  logic clk_i,
	input  logic rst_n_i,
	// Microwire from the MAC
	input  logic ee_sk_i,
	input  logic ee_cs_i,
	input  logic ee_di_i,
	output logic ee_do_o,
	// PHY ports
	input  nic_phy_pkg::phy_status_t phy0_status_i,
	input  nic_phy_pkg::phy_status_t phy1_status_i,
	input  nic_phy_pkg::gmii_rx_t phy0_rx_i,
	input  nic_phy_pkg::gmii_rx_t phy1_rx_i,
	output nic_phy_pkg::gmii_tx_t phy0_tx_o,
	output nic_phy_pkg::gmii_tx_t phy1_tx_o,
	// MAC side
	input  nic_phy_pkg::gmii_tx_t mac_tx_i,
	output nic_phy_pkg::gmii_rx_t mac_rx_o,
	output logic active_port_o,
	output logic link_up_o,
	output nic_phy_pkg::link_speed_e speed_o,
	output logic link_change_o
);
	import nic_phy_pkg::*;

	logic rom_rd_en;
	logic [EE_ADDR_W-1:0] rom_addr;
	logic [EE_WORD_W-1:0] rom_data;
	logic active_port;

	////////////////////////////////////////
	// EEPROM emulation

	config_rom #(
		.MAC_OUI(MAC_OUI),
		.MAC_NIC(MAC_NIC),
		.SUB_PID(SUB_PID),
		.SUB_VID(SUB_VID),
		.PID(PID),
		.VID(VID)
	) u_config_rom (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.rd_en_i(rom_rd_en),
		.rd_addr_i(rom_addr),
		.rd_data_o(rom_data)
	);

	eeprom_emu u_eeprom_emu (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.sk_i(ee_sk_i),
		.cs_i(ee_cs_i),
		.di_i(ee_di_i),
		.do_o(ee_do_o),
		.rom_rd_en_o(rom_rd_en),
		.rom_addr_o(rom_addr),
		.rom_data_i(rom_data)
	);

	////////////////////////////////////////
	// Dual PHY failover

	phy_failover #(
		.HOLDOFF_CYCLES(HOLDOFF_CYCLES)
	) u_phy_failover (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.phy0_status_i(phy0_status_i),
		.phy1_status_i(phy1_status_i),
		.active_port_o(active_port),
		.link_up_o(link_up_o),
		.speed_o(speed_o),
		.link_change_o(link_change_o)
	);

	assign active_port_o = active_port;

	gmii_port_mux u_gmii_port_mux (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.active_port_i(active_port),
		.phy0_rx_i(phy0_rx_i),
		.phy1_rx_i(phy1_rx_i),
		.mac_tx_i(mac_tx_i),
		.mac_rx_o(mac_rx_o),
		.phy0_tx_o(phy0_tx_o),
		.phy1_tx_o(phy1_tx_o)
	);

endmodule

// File: verilog/phy_failover.sv
module phy_failover #(
	parameter int HOLDOFF_CYCLES = 16
) (
	input  logic clk_i,
	input  logic rst_n_i,
	input  nic_phy_pkg::phy_status_t phy0_status_i,
	input  nic_phy_pkg::phy_status_t phy1_status_i,
	output logic active_port_o,
	output logic link_up_o,
	output nic_phy_pkg::link_speed_e speed_o,
	output logic link_change_o
);
	import nic_phy_pkg::*;

	localparam int CNT_W = $clog2(HOLDOFF_CYCLES + 1);

	phy_status_t act_st;
	phy_status_t stby_st;
	phy_status_t next_st;
	logic fail_cond;
	logic switch_now;
	logic [CNT_W-1:0] holdoff_cnt;
	logic link_up_q;
	logic active_q;

	assign act_st = active_port_o ? phy1_status_i : phy0_status_i;
	assign stby_st = active_port_o ? phy0_status_i : phy1_status_i;

	// Active down and standby up, nothing happens with both down
	assign fail_cond = !act_st.up && stby_st.up;
	assign switch_now = fail_cond && (holdoff_cnt == CNT_W'(HOLDOFF_CYCLES - 1));

	// Status of whichever port is active after this edge
	assign next_st = switch_now ? stby_st : act_st;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			holdoff_cnt <= '0;
			active_port_o <= 1'b0;
		end else if (!fail_cond || switch_now) begin
			holdoff_cnt <= '0;
			if (switch_now) begin
				active_port_o <= !active_port_o;
			end
		end else begin
			holdoff_cnt <= holdoff_cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Merged status and change pulse

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			link_up_o <= 1'b0;
			speed_o <= SPEED_10;
			link_up_q <= 1'b0;
			active_q <= 1'b0;
			link_change_o <= 1'b0;
		end else begin
			link_up_o <= next_st.up;
			speed_o <= next_st.speed;
			link_up_q <= link_up_o;
			active_q <= active_port_o;
			link_change_o <= (link_up_o != link_up_q) || (active_port_o != active_q);
		end
	end

	a_change_single: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		link_change_o |=> !link_change_o
	);

	a_switch_from_down: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		$changed(active_port_o) |-> !$past(act_st.up)
	);

endmodule
